// ==== src/bundlePkg.sv ====
`default_nettype none

package bundlePkg;

	// default register count, the top level overrides it
	parameter int regCountDefault = 16;

	typedef logic [3:0] regId;
	typedef logic [31:0] regValue;
	// zero-extended by the ALU
	typedef logic [7:0] immValue;

	typedef enum logic [2:0]
	{
		opNop = 3'd0,
		opAdd = 3'd1,
		opSub = 3'd2,
		opAnd = 3'd3,
		opOr  = 3'd4,
		opXor = 3'd5,
		opShl = 3'd6,
		opLdi = 3'd7
	} laneOp;

	// op, dest, s, t, imm from high to low bits
	typedef logic [22:0] laneWord;

	// lane A sits in the low bits
	typedef logic [68:0] bundleWord;

	typedef struct packed
	{
		logic    valid;
		laneOp   op;
		regId    dest;
		regId    srcS;
		regId    srcT;
		immValue imm;
	} decodedLane;

	typedef struct packed
	{
		logic    valid;
		regId    dest;
		regValue value;
	} laneResult;

endpackage

`default_nettype wire

// ==== src/bundleDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bundleDecoder
	import bundlePkg::*;
(
	input  wire            clock,
	input  wire            reset,
	input  wire            stall,
	input  wire            flush,
	input  wire bundleWord bundleIn,
	input  wire            bundleValid,
	output decodedLane     decodedA,
	output decodedLane     decodedB,
	output decodedLane     decodedC
);

	localparam int laneBits = $bits(laneWord);

	bundleWord bundleReg;
	logic      bundleRegValid;

	// turn one raw lane into issue controls
	function automatic decodedLane splitLane(laneWord word, logic live);
		decodedLane lane;
		lane = {live, word};
		// nothing to write back for nop or an empty slot
		if (!live || lane.op == opNop)
			lane.dest = '0;
		// ldi reads no registers
		if (lane.op == opLdi)
		begin
			lane.srcS = '0;
			lane.srcT = '0;
		end
		return lane;
	endfunction

	always_ff @(posedge clock)
	begin
		if (reset || flush)
			bundleRegValid <= 1'b0;
		else if (!stall)
			bundleRegValid <= bundleValid;
	end

	// bundle payload held under stall
	always_ff @(posedge clock)
	begin
		if (!stall)
			bundleReg <= bundleIn;
	end

	assign decodedA = splitLane(bundleReg[0 * laneBits +: laneBits], bundleRegValid);
	assign decodedB = splitLane(bundleReg[1 * laneBits +: laneBits], bundleRegValid);
	assign decodedC = splitLane(bundleReg[2 * laneBits +: laneBits], bundleRegValid);

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile
	import bundlePkg::*;
#(
	parameter int regCount = regCountDefault
)
(
	input  wire             clock,
	input  wire             reset,
	input  wire regId [5:0] readIds,
	output regValue [5:0]   readValues,
	input  wire laneResult  writeA,
	input  wire laneResult  writeB,
	input  wire laneResult  writeC
);

	regValue regs [regCount];

	// write-through, the same priority as the write side
	always_comb
	begin
		for (int i = 0; i < $size(readIds); i++)
		begin
			if (readIds[i] == '0)
				readValues[i] = '0;
			else if (writeA.valid && writeA.dest == readIds[i])
				readValues[i] = writeA.value;
			else if (writeB.valid && writeB.dest == readIds[i])
				readValues[i] = writeB.value;
			else if (writeC.valid && writeC.dest == readIds[i])
				readValues[i] = writeC.value;
			else
				readValues[i] = regs[readIds[i]];
		end
	end

	// later assignment wins, so C goes first and A last
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (writeC.valid && writeC.dest != '0)
				regs[writeC.dest] <= writeC.value;
			if (writeB.valid && writeB.dest != '0)
				regs[writeB.dest] <= writeB.value;
			if (writeA.valid && writeA.dest != '0)
				regs[writeA.dest] <= writeA.value;
		end
	end

endmodule

`default_nettype wire

// ==== src/operandLatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandLatch
	import bundlePkg::*;
(
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  hold,
	input  wire                  flush,
	input  wire bundlePkg::regId regId,
	input  wire regValue         regInVal,
	input  wire bundlePkg::regId wrIdA,
	input  wire regValue         wrValA,
	input  wire bundlePkg::regId wrIdB,
	input  wire regValue         wrValB,
	input  wire bundlePkg::regId wrIdC,
	input  wire regValue         wrValC,
	output regValue              regVal
);

	logic    isIdA;
	logic    isIdB;
	logic    isIdC;
	regValue nextVal;

	always_comb
	begin
		// r0 is never forwarded, flush drops forwarding entirely
		isIdA = !flush && regId != '0 && wrIdA == regId;
		isIdB = !flush && regId != '0 && wrIdB == regId;
		isIdC = !flush && regId != '0 && wrIdC == regId;
		casez ({isIdC, isIdB, isIdA})
			3'b??1:  nextVal = wrValA;
			3'b?10:  nextVal = wrValB;
			3'b100:  nextVal = wrValC;
			default: nextVal = regInVal;
		endcase
	end

	// flush wins over hold
	always_ff @(posedge clock)
	begin
		if (reset)
			regVal <= '0;
		else if (flush || !hold)
			regVal <= nextVal;
	end

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeStage
	import bundlePkg::*;
(
	input  wire             clock,
	input  wire             reset,
	input  wire             stall,
	input  wire             flush,
	input  wire decodedLane decodedA,
	input  wire decodedLane decodedB,
	input  wire decodedLane decodedC,
	input  wire regValue    operandSA,
	input  wire regValue    operandTA,
	input  wire regValue    operandSB,
	input  wire regValue    operandTB,
	input  wire regValue    operandSC,
	input  wire regValue    operandTC,
	output laneResult       laneResultA,
	output laneResult       laneResultB,
	output laneResult       laneResultC
);

	// controls of the bundle whose operands sit in the latches
	decodedLane ctrlA;
	decodedLane ctrlB;
	decodedLane ctrlC;

	// one lane ALU
	function automatic laneResult runLane(decodedLane ctrl, regValue s, regValue t);
		regValue   value;
		laneResult result;
		case (ctrl.op)
			opAdd:   value = s + t;
			opSub:   value = s - t;
			opAnd:   value = s & t;
			opOr:    value = s | t;
			opXor:   value = s ^ t;
			opShl:   value = s << t[4:0];
			opLdi:   value = regValue'(ctrl.imm);
			default: value = '0;
		endcase
		result.valid = ctrl.valid;
		result.dest = ctrl.dest;
		result.value = value;
		return result;
	endfunction

	// a cleared entry is a nop with dest r0, so nothing forwards from it
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			ctrlA <= '0;
			ctrlB <= '0;
			ctrlC <= '0;
		end
		else if (!stall)
		begin
			ctrlA <= decodedA;
			ctrlB <= decodedB;
			ctrlC <= decodedC;
		end
	end

	assign laneResultA = runLane(ctrlA, operandSA, operandTA);
	assign laneResultB = runLane(ctrlB, operandSB, operandTB);
	assign laneResultC = runLane(ctrlC, operandSC, operandTC);

endmodule

`default_nettype wire

// ==== src/resultStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultStage
	import bundlePkg::*;
(
	input  wire            clock,
	input  wire            reset,
	input  wire            stall,
	input  wire            flush,
	input  wire laneResult laneResultA,
	input  wire laneResult laneResultB,
	input  wire laneResult laneResultC,
	output laneResult      resultA,
	output laneResult      resultB,
	output laneResult      resultC
);

	localparam laneResult bubble = '0;

	// stall leaves the execute results in place, so a bubble here
	// keeps each result from retiring twice
	always_ff @(posedge clock)
	begin
		if (reset || flush || stall)
		begin
			resultA <= bubble;
			resultB <= bubble;
			resultC <= bubble;
		end
		else
		begin
			resultA <= laneResultA;
			resultB <= laneResultB;
			resultC <= laneResultC;
		end
	end

endmodule

`default_nettype wire

// ==== src/bundleCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module bundleCore
	import bundlePkg::*;
#(
	parameter int regCount = regCountDefault
)
(
	input  wire            clock,
	input  wire            reset,
	input  wire bundleWord bundleIn,
	input  wire            bundleValid,
	input  wire            stall,
	input  wire            flush,
	output laneResult      resultA,
	output laneResult      resultB,
	output laneResult      resultC
);

	decodedLane decodedA;
	decodedLane decodedB;
	decodedLane decodedC;
	laneResult  laneResultA;
	laneResult  laneResultB;
	laneResult  laneResultC;
	regValue [5:0] readValues;
	wire regValue [5:0] operands;

	// port order is A.s, A.t, B.s, B.t, C.s, C.t
	wire regId [5:0] readIds = {decodedC.srcT, decodedC.srcS, decodedB.srcT,
		decodedB.srcS, decodedA.srcT, decodedA.srcS};

	bundleDecoder u_decoder (
		.clock(clock), .reset(reset), .stall(stall), .flush(flush),
		.bundleIn(bundleIn), .bundleValid(bundleValid),
		.decodedA(decodedA), .decodedB(decodedB), .decodedC(decodedC)
	);

	registerFile #(.regCount(regCount)) u_regFile (
		.clock(clock), .reset(reset),
		.readIds(readIds), .readValues(readValues),
		.writeA(resultA), .writeB(resultB), .writeC(resultC)
	);

	// one latch per lane source, fed back from execute
	for (genvar i = 0; i < 6; i++)
	begin : gOperand
		operandLatch u_latch (
			.clock(clock), .reset(reset), .hold(stall), .flush(flush),
			.regId(readIds[i]), .regInVal(readValues[i]),
			.wrIdA(laneResultA.dest), .wrValA(laneResultA.value),
			.wrIdB(laneResultB.dest), .wrValB(laneResultB.value),
			.wrIdC(laneResultC.dest), .wrValC(laneResultC.value),
			.regVal(operands[i])
		);
	end

	executeStage u_execute (
		.clock(clock), .reset(reset), .stall(stall), .flush(flush),
		.decodedA(decodedA), .decodedB(decodedB), .decodedC(decodedC),
		.operandSA(operands[0]), .operandTA(operands[1]),
		.operandSB(operands[2]), .operandTB(operands[3]),
		.operandSC(operands[4]), .operandTC(operands[5]),
		.laneResultA(laneResultA), .laneResultB(laneResultB),
		.laneResultC(laneResultC)
	);

	resultStage u_result (
		.clock(clock), .reset(reset), .stall(stall), .flush(flush),
		.laneResultA(laneResultA), .laneResultB(laneResultB),
		.laneResultC(laneResultC),
		.resultA(resultA), .resultB(resultB), .resultC(resultC)
	);

endmodule

`default_nettype wire

// ==== tb/bundleCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bundleCoreTb
	import bundlePkg::*;
;

	localparam int tableLen = 17;
	localparam int randomCount = 24;
	localparam int cycleLimit = tableLen + randomCount + 20;

	logic      clock;
	logic      reset;
	bundleWord bundleIn;
	logic      bundleValid;
	logic      stall;
	logic      flush;
	laneResult resultA;
	laneResult resultB;
	laneResult resultC;

	// stimulus table with one bundle per row
	bundleWord rowBundle [tableLen];
	logic      rowValid [tableLen];
	logic      rowStall [tableLen];
	logic      rowFlush [tableLen];
	regValue   rowExp [tableLen][3];

	// shadow of the architectural state and of the pipeline slots
	regValue   shadow [16];
	bundleWord decBundle;
	bundleWord exBundle;
	logic      decValid;
	logic      exValid;
	int        decRow;
	int        exRow;
	int        curRow;
	laneResult expRes [3];
	logic      expLive;
	int        expRow;

	logic [15:0] lfsrState;
	int          errors;
	int          checks;
	int          cycleCount;

	bundleCore #(.regCount(16)) u_bundleCore (
		.clock(clock), .reset(reset),
		.bundleIn(bundleIn), .bundleValid(bundleValid),
		.stall(stall), .flush(flush),
		.resultA(resultA), .resultB(resultB), .resultC(resultC)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic laneWord makeLane(laneOp op, regId d, regId s, regId t, immValue imm);
		return {op, d, s, t, imm};
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	// expected result of one lane from the state before its bundle
	function automatic laneResult predictLane(laneWord w);
		laneOp     op;
		regValue   s;
		regValue   t;
		laneResult r;
		op = laneOp'(w[22:20]);
		s = shadow[w[15:12]];
		t = shadow[w[11:8]];
		r.valid = 1'b1;
		r.dest = (op == opNop) ? 4'd0 : w[19:16];
		case (op)
			opAdd:   r.value = s + t;
			opSub:   r.value = s - t;
			opAnd:   r.value = s & t;
			opOr:    r.value = s | t;
			opXor:   r.value = s ^ t;
			opShl:   r.value = s << t[4:0];
			opLdi:   r.value = {24'd0, w[7:0]};
			default: r.value = '0;
		endcase
		return r;
	endfunction

	task automatic setRow(input int i, input laneWord a, input laneWord b, input laneWord c,
		input logic v, input logic st, input logic fl,
		input regValue ea, input regValue eb, input regValue ec);
		rowBundle[i] = {c, b, a};
		rowValid[i] = v;
		rowStall[i] = st;
		rowFlush[i] = fl;
		rowExp[i][0] = ea;
		rowExp[i][1] = eb;
		rowExp[i][2] = ec;
	endtask

	task automatic loadTable();
		laneWord nop;
		laneWord a11;
		laneWord b11;
		laneWord c11;
		nop = makeLane(opNop, 4'd0, 4'd0, 4'd0, 8'h00);
		a11 = makeLane(opAdd, 4'd6, 4'd4, 4'd5, 8'h00);
		b11 = makeLane(opShl, 4'd7, 4'd5, 4'd5, 8'h00);
		c11 = makeLane(opXor, 4'd8, 4'd4, 4'd4, 8'h00);
		// every op with forwarding and write-through
		setRow(0, makeLane(opLdi, 4'd1, 4'd0, 4'd0, 8'h05), makeLane(opLdi, 4'd2, 4'd0, 4'd0, 8'h03),
			makeLane(opLdi, 4'd3, 4'd0, 4'd0, 8'hF0), 1, 0, 0, 32'h5, 32'h3, 32'hF0);
		setRow(1, makeLane(opAdd, 4'd4, 4'd1, 4'd2, 8'h00), makeLane(opSub, 4'd5, 4'd1, 4'd2, 8'h00),
			makeLane(opAnd, 4'd6, 4'd3, 4'd1, 8'h00), 1, 0, 0, 32'h8, 32'h2, 32'h0);
		setRow(2, makeLane(opOr, 4'd7, 4'd3, 4'd1, 8'h00), makeLane(opXor, 4'd8, 4'd1, 4'd2, 8'h00),
			makeLane(opShl, 4'd9, 4'd1, 4'd2, 8'h00), 1, 0, 0, 32'hF5, 32'h6, 32'h28);
		setRow(3, makeLane(opAdd, 4'd10, 4'd4, 4'd5, 8'h00), makeLane(opAdd, 4'd11, 4'd7, 4'd8, 8'h00),
			makeLane(opSub, 4'd12, 4'd2, 4'd1, 8'h00), 1, 0, 0, 32'hA, 32'hFB, 32'hFFFFFFFE);
		// same destination in several lanes
		setRow(4, makeLane(opLdi, 4'd1, 4'd0, 4'd0, 8'h11), makeLane(opLdi, 4'd1, 4'd0, 4'd0, 8'h22),
			makeLane(opLdi, 4'd1, 4'd0, 4'd0, 8'h33), 1, 0, 0, 32'h11, 32'h22, 32'h33);
		setRow(5, makeLane(opLdi, 4'd2, 4'd0, 4'd0, 8'h44), makeLane(opLdi, 4'd2, 4'd0, 4'd0, 8'h55),
			makeLane(opAdd, 4'd13, 4'd2, 4'd1, 8'h00), 1, 0, 0, 32'h44, 32'h55, 32'h14);
		setRow(6, nop, makeLane(opLdi, 4'd3, 4'd0, 4'd0, 8'h66),
			makeLane(opLdi, 4'd3, 4'd0, 4'd0, 8'h77), 1, 0, 0, 32'h0, 32'h66, 32'h77);
		// r0 write is dropped
		setRow(7, makeLane(opAdd, 4'd14, 4'd1, 4'd2, 8'h00), makeLane(opLdi, 4'd0, 4'd0, 4'd0, 8'h99),
			makeLane(opAdd, 4'd15, 4'd3, 4'd0, 8'h00), 1, 0, 0, 32'h55, 32'h99, 32'h66);
		setRow(8, makeLane(opAdd, 4'd4, 4'd0, 4'd1, 8'h00), makeLane(opLdi, 4'd5, 4'd0, 4'd0, 8'h0A),
			nop, 1, 0, 0, 32'h11, 32'hA, 32'h0);
		// two stall cycles with the next bundle held steady
		setRow(9, a11, b11, c11, 1, 1, 0, 32'h0, 32'h0, 32'h0);
		setRow(10, a11, b11, c11, 1, 1, 0, 32'h0, 32'h0, 32'h0);
		setRow(11, a11, b11, c11, 1, 0, 0, 32'h1B, 32'h2800, 32'h0);
		setRow(12, nop, nop, nop, 1, 0, 0, 32'h0, 32'h0, 32'h0);
		// rows 13 and 14 are squashed by the flush in row 15
		setRow(13, makeLane(opLdi, 4'd9, 4'd0, 4'd0, 8'h5A), makeLane(opLdi, 4'd10, 4'd0, 4'd0, 8'h5B),
			makeLane(opLdi, 4'd1, 4'd0, 4'd0, 8'h99), 1, 0, 0, 32'h0, 32'h0, 32'h0);
		setRow(14, makeLane(opLdi, 4'd2, 4'd0, 4'd0, 8'hAB), nop, nop, 1, 0, 0,
			32'h0, 32'h0, 32'h0);
		setRow(15, nop, nop, nop, 0, 0, 1, 32'h0, 32'h0, 32'h0);
		setRow(16, makeLane(opAdd, 4'd12, 4'd9, 4'd10, 8'h00), makeLane(opAdd, 4'd13, 4'd1, 4'd0, 8'h00),
			makeLane(opAdd, 4'd14, 4'd2, 4'd0, 8'h00), 1, 0, 0, 32'h32, 32'h11, 32'h44);
	endtask

	// one clock edge of the shadow pipeline on the inputs held before it
	task automatic advanceModel();
		bundleWord retBundle;
		expLive = 1'b0;
		if (flush)
		begin
			decValid = 1'b0;
			exValid = 1'b0;
		end
		else if (!stall)
		begin
			expLive = exValid;
			expRow = exRow;
			retBundle = exBundle;
			exBundle = decBundle;
			exValid = decValid;
			exRow = decRow;
			decBundle = bundleIn;
			decValid = bundleValid;
			decRow = curRow;
			if (expLive)
			begin
				for (int l = 0; l < 3; l++)
					expRes[l] = predictLane(retBundle[l * 23 +: 23]);
				// A applied last so it wins
				for (int l = 2; l >= 0; l--)
					if (expRes[l].dest != 4'd0)
						shadow[expRes[l].dest] = expRes[l].value;
			end
		end
	endtask

	task automatic checkLane(input string name, input int lane, input laneResult got);
		laneResult exp;
		exp = expRes[lane];
		checks++;
		if (!expLive)
		begin
			assert (got.valid == 1'b0) else
			begin
				errors++;
				$display("mismatch at %0t: %s.valid expected 0 actual %b", $time, name, got.valid);
			end
		end
		else
		begin
			assert (got.valid == 1'b1 && got.dest == exp.dest) else
			begin
				errors++;
				$display("mismatch at %0t: %s.dest expected %h actual %h (valid %b)",
					$time, name, exp.dest, got.dest, got.valid);
			end
			assert (got.value == exp.value) else
			begin
				errors++;
				$display("mismatch at %0t: %s.value expected %h actual %h",
					$time, name, exp.value, got.value);
			end
			if (expRow >= 0)
			begin
				assert (got.value == rowExp[expRow][lane]) else
				begin
					errors++;
					$display("mismatch at %0t: %s.value (row %0d) expected %h actual %h",
						$time, name, expRow, rowExp[expRow][lane], got.value);
				end
			end
		end
	endtask

	task automatic stepAndCheck();
		@(posedge clock);
		#1;
		advanceModel();
		checkLane("resultA", 0, resultA);
		checkLane("resultB", 1, resultB);
		checkLane("resultC", 2, resultC);
	endtask

	// watchdog
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			if (!reset)
				cycleCount++;
		end
		errors++;
		$display("timeout before all results arrived");
		$display("checks %0d, errors %0d", checks, errors);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		reset = 1'b1;
		bundleIn = '0;
		bundleValid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		errors = 0;
		checks = 0;
		lfsrState = 16'd46693;
		decValid = 1'b0;
		exValid = 1'b0;
		decRow = -1;
		exRow = -1;
		curRow = -1;
		expLive = 1'b0;
		expRow = -1;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		loadTable();
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 0; i < tableLen + randomCount; i++)
		begin
			if (i < tableLen)
			begin
				bundleIn = rowBundle[i];
				bundleValid = rowValid[i];
				stall = rowStall[i];
				flush = rowFlush[i];
				curRow = i;
			end
			else
			begin
				drawBits(23, a);
				drawBits(23, b);
				drawBits(23, c);
				bundleIn = {c[22:0], b[22:0], a[22:0]};
				bundleValid = 1'b1;
				stall = 1'b0;
				flush = 1'b0;
				curRow = -1;
			end
			stepAndCheck();
		end

		// drain until the shadow pipeline is empty
		bundleValid = 1'b0;
		curRow = -1;
		do
			stepAndCheck();
		while (decValid || exValid || expLive);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
src/bundlePkg.sv
src/bundleDecoder.sv
src/registerFile.sv
src/operandLatch.sv
src/executeStage.sv
src/resultStage.sv
src/bundleCore.sv
tb/bundleCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bundleCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module bundleCoreTb -f tb.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
